/* source/riscv_pkg.sv */
// RV32I shared definitions
package riscv_pkg;

    // Datapath widths
    localparam int DWIDTH    = 32;               // Register and result width
    localparam int AWIDTH    = 32;               // PC and address width
    localparam int REG_COUNT = 32;               // Architectural registers

    // Vector types
    typedef logic [DWIDTH-1:0]            word_t;     // Data word
    typedef logic [AWIDTH-1:0]            addr_t;     // PC or memory address
    typedef logic [31:0]                  instr_t;    // Raw instruction word
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;  // Register index
    typedef logic [6:0]                   opcode_t;   // Major opcode, instr[6:0]
    typedef logic [2:0]                   funct3_t;   // instr[14:12]
    typedef logic [6:0]                   funct7_t;   // instr[31:25]

    // Major opcodes
    localparam opcode_t OPCODE_OP     = 7'b0110011;  // Register-register ALU
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;

    // Funct3 for OP and OP-IMM
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;    // ADD, SUB, ADDI
    localparam funct3_t FUNCT3_SLL     = 3'b001;    // SLL, SLLI
    localparam funct3_t FUNCT3_SLT     = 3'b010;    // SLT, SLTI
    localparam funct3_t FUNCT3_SLTU    = 3'b011;    // SLTU, SLTIU
    localparam funct3_t FUNCT3_XOR     = 3'b100;    // XOR, XORI
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;    // Right shifts
    localparam funct3_t FUNCT3_OR      = 3'b110;    // OR, ORI
    localparam funct3_t FUNCT3_AND     = 3'b111;    // AND, ANDI

    // Funct3 for BRANCH
    localparam funct3_t FUNCT3_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BLT  = 3'b100;       // Signed less-than
    localparam funct3_t FUNCT3_BGE  = 3'b101;       // Signed greater-or-equal
    localparam funct3_t FUNCT3_BLTU = 3'b110;       // Unsigned less-than
    localparam funct3_t FUNCT3_BGEU = 3'b111;       // Unsigned greater-or-equal

    // Alternate-operation funct7, bit 30 of the instruction set
    localparam funct7_t FUNCT7_SUB = 7'b0100000;    // SUB instead of ADD
    localparam funct7_t FUNCT7_SRA = 7'b0100000;    // Arithmetic right shift

endpackage : riscv_pkg

/* source/branch_control.sv */
// Branch operand comparator
`timescale 1ns/1ps

module branch_control
    import riscv_pkg::*;
(
    input  opcode_t opcode_i,     // Decoded opcode
    input  funct3_t funct3_i,     // Branch condition select
    input  word_t   rs1_i,        // First register operand
    input  word_t   rs2_i,        // Second register operand
    output logic    breq_o,       // Operands equal
    output logic    brlt_o        // rs1 below rs2
);

    logic is_unsigned;            // Unsigned compare requested

    // Only BLTU and BGEU compare unsigned
    assign is_unsigned = (opcode_i == OPCODE_BRANCH) &&
                         ((funct3_i == FUNCT3_BLTU) || (funct3_i == FUNCT3_BGEU));

    assign breq_o = (rs1_i == rs2_i);

    always_comb begin
        if (is_unsigned) begin
            brlt_o = (rs1_i < rs2_i);                     // Plain magnitude
        end else begin
            brlt_o = ($signed(rs1_i) < $signed(rs2_i));   // Two's complement
        end
    end

endmodule : branch_control

/* source/alu.sv */
// Execute-stage ALU
`timescale 1ns/1ps

module alu
    import riscv_pkg::*;
(
    input  addr_t   pc_i,         // PC of this instruction
    input  word_t   rs1_i,        // rs1 read data
    input  word_t   rs2_i,        // rs2 read data
    input  word_t   imm_i,        // Sign-extended immediate
    input  opcode_t opcode_i,
    input  funct3_t funct3_i,
    input  funct7_t funct7_i,     // Zero unless OP or OP-IMM shift
    output word_t   res_o,        // Result, target or address
    output logic    brtaken_o     // Control transfer taken
);

    logic  breq;                  // rs1 == rs2
    logic  brlt;                  // rs1 < rs2, sign per funct3
    word_t op_b;                  // Second ALU operand
    word_t arith_res;             // OP / OP-IMM result
    logic  cond;                  // Branch condition outcome
    logic  [4:0] shamt;           // Shift amount

    // Comparator sees the real opcode so BLTU/BGEU go unsigned
    branch_control u_branch_control (
        .opcode_i (opcode_i),
        .funct3_i (funct3_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .breq_o   (breq),
        .brlt_o   (brlt)
    );

    assign op_b  = (opcode_i == OPCODE_OP_IMM) ? imm_i : rs2_i;  // Immediate form
    assign shamt = op_b[4:0];

    // Integer operations shared by OP and OP-IMM
    always_comb begin
        case (funct3_i)
            FUNCT3_ADD_SUB: begin
                if ((opcode_i == OPCODE_OP) && (funct7_i == FUNCT7_SUB)) begin
                    arith_res = rs1_i - op_b;                   // SUB
                end else begin
                    arith_res = rs1_i + op_b;                   // ADD, ADDI
                end
            end
            FUNCT3_SLL:  arith_res = rs1_i << shamt;
            FUNCT3_SLT:  arith_res = ($signed(rs1_i) < $signed(op_b)) ? 32'd1 : 32'd0;
            FUNCT3_SLTU: arith_res = (rs1_i < op_b) ? 32'd1 : 32'd0;
            FUNCT3_XOR:  arith_res = rs1_i ^ op_b;
            FUNCT3_SRL_SRA: begin
                if (funct7_i == FUNCT7_SRA) begin
                    arith_res = $signed(rs1_i) >>> shamt;      // Sign fill
                end else begin
                    arith_res = rs1_i >> shamt;                 // Zero fill
                end
            end
            FUNCT3_OR:   arith_res = rs1_i | op_b;
            default:     arith_res = rs1_i & op_b;               // FUNCT3_AND
        endcase
    end

    // Branch condition from comparator flags
    always_comb begin
        case (funct3_i)
            FUNCT3_BEQ:  cond = breq;
            FUNCT3_BNE:  cond = ~breq;
            FUNCT3_BLT:  cond = brlt;
            FUNCT3_BGE:  cond = ~brlt;
            FUNCT3_BLTU: cond = brlt;
            FUNCT3_BGEU: cond = ~brlt;
            default:     cond = 1'b0;                           // Reserved encodings
        endcase
    end

    // Result select by opcode
    always_comb begin
        res_o     = '0;
        brtaken_o = 1'b0;
        case (opcode_i)
            OPCODE_OP, OPCODE_OP_IMM: res_o = arith_res;
            OPCODE_BRANCH: begin
                res_o     = pc_i + imm_i;                       // Branch target
                brtaken_o = cond;
            end
            OPCODE_LOAD, OPCODE_STORE: res_o = rs1_i + imm_i;   // Effective address
            OPCODE_JAL, OPCODE_JALR: begin
                res_o     = pc_i + 32'd4;                       // Return address
                brtaken_o = 1'b1;
            end
            OPCODE_LUI:   res_o = imm_i;                        // Upper immediate
            OPCODE_AUIPC: res_o = pc_i + imm_i;
            default: begin
                res_o     = '0;
                brtaken_o = 1'b0;
            end
        endcase
    end

endmodule : alu

/* source/decoder.sv */
// RV32I instruction decoder
`timescale 1ns/1ps

module decoder
    import riscv_pkg::*;
(
    input  instr_t   instr_i,     // Raw instruction
    output reg_idx_t rs1_idx_o,   // Source register 1
    output reg_idx_t rs2_idx_o,   // Source register 2
    output reg_idx_t rd_idx_o,    // Destination register
    output word_t    imm_o,       // Sign-extended immediate
    output opcode_t  opcode_o,
    output funct3_t  funct3_o,
    output funct7_t  funct7_o,    // Masked funct7
    output logic     wb_en_o      // Writes a register
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7_raw;          // instr[31:25] as fetched
    logic    is_shift_imm;        // SLLI, SRLI, SRAI
    logic    writes_rd;           // Opcode class writes rd
    word_t   imm_i_type;
    word_t   imm_s_type;
    word_t   imm_b_type;
    word_t   imm_u_type;
    word_t   imm_j_type;

    // Fixed-position fields
    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7_raw = instr_i[31:25];

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign rd_idx_o  = instr_i[11:7];
    assign opcode_o  = opcode;
    assign funct3_o  = funct3;

    // Immediate formats, sign bit is always instr[31]
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: imm_o = imm_i_type;
            OPCODE_STORE:                            imm_o = imm_s_type;
            OPCODE_BRANCH:                           imm_o = imm_b_type;
            OPCODE_LUI, OPCODE_AUIPC:                imm_o = imm_u_type;
            OPCODE_JAL:                              imm_o = imm_j_type;
            default:                                 imm_o = '0;  // OP has none
        endcase
    end

    assign is_shift_imm = (opcode == OPCODE_OP_IMM) &&
                          ((funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL_SRA));

    // Keep ADDI from turning into SUB
    always_comb begin
        if ((opcode == OPCODE_OP) || is_shift_imm) begin
            funct7_o = funct7_raw;
        end else begin
            funct7_o = '0;
        end
    end

    // Register-writing classes
    always_comb begin
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI,
            OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR: writes_rd = 1'b1;
            default:                               writes_rd = 1'b0;  // Branch, load, store
        endcase
    end

    assign wb_en_o = writes_rd && (rd_idx_o != '0);  // x0 never written

endmodule : decoder

/* source/regfile.sv */
// Integer register file
`timescale 1ns/1ps

module regfile
    import riscv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  reg_idx_t rs1_idx_i,   // Read port 1 index
    input  reg_idx_t rs2_idx_i,   // Read port 2 index
    input  logic     wr_en_i,     // Write strobe
    input  reg_idx_t rd_idx_i,    // Write index
    input  word_t    rd_data_i,   // Write data
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs [REG_COUNT];      // x0 entry stays zero

    // Single write port
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_idx_i != '0)) begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // Asynchronous reads, index 0 hardwired
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule : regfile

/* source/execute_stage.sv */
// RV32I execute stage top level
`timescale 1ns/1ps

module execute_stage
    import riscv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,     // Instruction present this cycle
    input  instr_t   instr_i,
    input  addr_t    pc_i,
    output logic     valid_o,     // Result valid, one cycle later
    output word_t    res_o,
    output logic     brtaken_o,
    output reg_idx_t rd_o         // Destination of the result
);

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    word_t    imm;
    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    logic     wb_en;              // Decoded write-back class
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_res;
    logic     alu_brtaken;
    logic     wr_en;              // Qualified register write

    decoder u_decoder (
        .instr_i   (instr_i),
        .rs1_idx_o (rs1_idx),
        .rs2_idx_o (rs2_idx),
        .rd_idx_o  (rd_idx),
        .imm_o     (imm),
        .opcode_o  (opcode),
        .funct3_o  (funct3),
        .funct7_o  (funct7),
        .wb_en_o   (wb_en)
    );

    // Write lands on the same edge as the output capture
    assign wr_en = valid_i & wb_en;

    regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .wr_en_i    (wr_en),
        .rd_idx_i   (rd_idx),
        .rd_data_i  (alu_res),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu u_alu (
        .pc_i      (pc_i),
        .rs1_i     (rs1_data),
        .rs2_i     (rs2_data),
        .imm_i     (imm),
        .opcode_i  (opcode),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .res_o     (alu_res),
        .brtaken_o (alu_brtaken)
    );

    // Output register, holds last result when idle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            res_o     <= '0;
            brtaken_o <= 1'b0;
            rd_o      <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                res_o     <= alu_res;
                brtaken_o <= alu_brtaken;
                rd_o      <= rd_idx;
            end
        end
    end

endmodule : execute_stage

/* test/execute_checker.sv */
// Execute stage assertions
`timescale 1ns/1ps

module execute_checker
    import riscv_pkg::*;
(
    input logic     clk_i,
    input logic     arst_n_i,
    input logic     valid_i,      // DUT valid_o
    input logic     brtaken_i,    // DUT brtaken_o
    input reg_idx_t rd_i          // DUT rd_o
);

    // No result while reset is held
    valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !valid_i)
        else $error("valid_o high during reset");

    // First edge after release has nothing captured yet
    valid_after_release: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !valid_i)
        else $error("valid_o high in the cycle after reset release");

    // Idle cycles keep the last flag
    brtaken_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !valid_i |-> $stable(brtaken_i))
        else $error("brtaken_o changed while valid_o was low");

    rd_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> !$isunknown(rd_i))
        else $error("rd_o unknown while valid_o high");

endmodule : execute_checker

bind execute_stage execute_checker u_execute_checker (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_o),
    .brtaken_i (brtaken_o),
    .rd_i      (rd_o)
);

/* test/execute_tb.sv */
// Execute stage testbench
`timescale 1ns/1ps

module execute_tb
    import riscv_pkg::*;
();

    logic     clk = 1'b0;
    logic     arst_n;
    logic     valid;                // Instruction strobe into DUT
    instr_t   instr;
    addr_t    pc;
    logic     out_valid;
    word_t    res;
    logic     brtaken;
    reg_idx_t rd;

    word_t       mirror [REG_COUNT];  // Expected architectural registers
    addr_t       pc_now;              // PC of the next issued instruction
    logic [31:0] lfsr_state;
    word_t       last_res;            // Last expected result, held while idle
    logic        last_br;
    reg_idx_t    last_rd;

    execute_stage DUT (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .valid_i   (valid),
        .instr_i   (instr),
        .pc_i      (pc),
        .valid_o   (out_valid),
        .res_o     (res),
        .brtaken_o (brtaken),
        .rd_o      (rd)
    );

    always #10 clk = ~clk;            // 20 ns period

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ 32'h80200003;
        return lsb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    // Instruction encoders, immediates passed as full words
    function automatic instr_t enc_r(funct7_t f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                     reg_idx_t rdi);
        return {f7, rs2, rs1, f3, rdi, OPCODE_OP};
    endfunction

    function automatic instr_t enc_i(opcode_t op, word_t imm, reg_idx_t rs1, funct3_t f3,
                                     reg_idx_t rdi);
        return {imm[11:0], rs1, f3, rdi, op};
    endfunction

    function automatic instr_t enc_s(word_t imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};  // SW
    endfunction

    function automatic instr_t enc_b(word_t imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic instr_t enc_u(opcode_t op, word_t imm, reg_idx_t rdi);
        return {imm[31:12], rdi, op};
    endfunction

    function automatic instr_t enc_j(word_t imm, reg_idx_t rdi);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rdi, OPCODE_JAL};
    endfunction

    function automatic word_t sext12(word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic word_t sext13(word_t v);
        return {{19{v[12]}}, v[12:1], 1'b0};  // Branch offsets are even
    endfunction

    // Reference model, RV32I integer semantics
    function automatic logic signed_lt(word_t a, word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);  // Differing signs decide alone
    endfunction

    function automatic word_t arith_ref(funct3_t f3, logic alt, word_t a, word_t b);
        word_t sra;
        sra = a >> b[4:0];
        if (a[31]) sra = sra | ~(32'hffffffff >> b[4:0]);  // Refill sign bits
        case (f3)
            FUNCT3_ADD_SUB: return alt ? a - b : a + b;
            FUNCT3_SLL:     return a << b[4:0];
            FUNCT3_SLT:     return signed_lt(a, b) ? 32'd1 : 32'd0;
            FUNCT3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            FUNCT3_XOR:     return a ^ b;
            FUNCT3_SRL_SRA: return alt ? sra : a >> b[4:0];
            FUNCT3_OR:      return a | b;
            default:        return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(funct3_t f3, word_t a, word_t b);
        case (f3)
            FUNCT3_BEQ:  return a == b;
            FUNCT3_BNE:  return a != b;
            FUNCT3_BLT:  return signed_lt(a, b);
            FUNCT3_BGE:  return !signed_lt(a, b);
            FUNCT3_BLTU: return a < b;
            FUNCT3_BGEU: return !(a < b);
            default:     return 1'b0;
        endcase
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "flag compare failed");
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected x%0d actual x%0d", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "register index compare failed");
        end
    endtask

    task automatic wait_valid(input string name);
        int waited;
        waited = 0;
        while (!out_valid) begin
            if (waited >= 5) begin
                $display("Timeout in %s, valid_o never went high", name);
                $display("ERRORS FOUND");
                $fatal(1, "valid_o timeout");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // Issue one instruction, check its result, track the write in the mirror
    task automatic run(input string name, input instr_t ins, input word_t exp_res,
                       input logic exp_br, input logic writes);
        reg_idx_t rdi;
        rdi   = ins[11:7];
        valid = 1'b1;
        instr = ins;
        pc    = pc_now;
        @(posedge clk);
        #1;
        valid  = 1'b0;             // Next call may raise it again at once
        pc_now = pc_now + 32'd4;
        wait_valid(name);
        compare_word(name, exp_res, res);
        compare_flag(name, exp_br, brtaken);
        compare_reg(name, rdi, rd);
        last_res = exp_res;
        last_br  = exp_br;
        last_rd  = rdi;
        if (writes && (rdi != 5'd0)) mirror[rdi] = exp_res;
    endtask

    // Idle cycles with valid low, outputs keep the last result
    task automatic idle_hold(input string name, input int cycles);
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
            #1;
            compare_flag(name, 1'b0, out_valid);
            compare_word(name, last_res, res);
            compare_flag(name, last_br, brtaken);
            compare_reg(name, last_rd, rd);
        end
    endtask

    task automatic run_op(input string name, input funct7_t f7, input funct3_t f3,
                          input reg_idx_t rdi, input reg_idx_t rs1, input reg_idx_t rs2);
        run(name, enc_r(f7, rs2, rs1, f3, rdi),
            arith_ref(f3, f7[5], mirror[rs1], mirror[rs2]), 1'b0, 1'b1);
    endtask

    task automatic run_op_imm(input string name, input funct3_t f3, input word_t imm,
                              input reg_idx_t rs1, input reg_idx_t rdi);
        logic alt;
        alt = (f3 == FUNCT3_SRL_SRA) && imm[10];    // SRAI marker
        run(name, enc_i(OPCODE_OP_IMM, imm, rs1, f3, rdi),
            arith_ref(f3, alt, mirror[rs1], sext12(imm)), 1'b0, 1'b1);
    endtask

    task automatic readback(input reg_idx_t idx);
        run_op($sformatf("readback x%0d", idx), 7'd0, FUNCT3_OR, 5'd31, idx, 5'd0);
    endtask

    task automatic test_reset();
        compare_flag("reset valid_o", 1'b0, out_valid);
        compare_flag("reset brtaken_o", 1'b0, brtaken);
        compare_word("reset res_o", '0, res);
        compare_reg("reset rd_o", 5'd0, rd);
        run("add after reset", enc_r(7'd0, 5'd7, 5'd3, FUNCT3_ADD_SUB, 5'd5), '0, 1'b0, 1'b1);
    endtask

    task automatic test_arith();
        word_t hi;
        word_t lo;
        for (int i = 1; i <= 8; i++) begin
            hi     = rand_bits(20) << 12;
            hi[31] = i[0];                           // Odd registers negative
            run($sformatf("lui x%0d", i), enc_u(OPCODE_LUI, hi, reg_idx_t'(i)),
                hi, 1'b0, 1'b1);
            lo = rand_bits(12);
            run_op_imm($sformatf("addi x%0d", i), FUNCT3_ADD_SUB, lo,
                       reg_idx_t'(i), reg_idx_t'(i));
        end
        run_op("add", 7'd0, FUNCT3_ADD_SUB, 5'd10, 5'd1, 5'd2);
        run_op("sub", FUNCT7_SUB, FUNCT3_ADD_SUB, 5'd11, 5'd3, 5'd4);
        run_op("xor", 7'd0, FUNCT3_XOR, 5'd12, 5'd5, 5'd6);
        run_op("or", 7'd0, FUNCT3_OR, 5'd13, 5'd7, 5'd8);
        run_op("and", 7'd0, FUNCT3_AND, 5'd14, 5'd1, 5'd8);
        run_op_imm("addi to x0", FUNCT3_ADD_SUB, 32'd5, 5'd1, 5'd0);
        run_op("read x0", 7'd0, FUNCT3_ADD_SUB, 5'd15, 5'd0, 5'd0);
    endtask

    task automatic test_shift_compare();
        run_op("sll", 7'd0, FUNCT3_SLL, 5'd16, 5'd1, 5'd2);
        run_op("srl", 7'd0, FUNCT3_SRL_SRA, 5'd17, 5'd1, 5'd4);
        run_op("sra", FUNCT7_SRA, FUNCT3_SRL_SRA, 5'd18, 5'd3, 5'd6);
        run_op_imm("srai", FUNCT3_SRL_SRA, {20'd0, FUNCT7_SRA, 5'd7}, 5'd5, 5'd19);
        run_op("slt neg pos", 7'd0, FUNCT3_SLT, 5'd20, 5'd1, 5'd2);   // Signed says 1
        run_op("sltu neg pos", 7'd0, FUNCT3_SLTU, 5'd21, 5'd1, 5'd2); // Unsigned says 0
        run_op("slt pos neg", 7'd0, FUNCT3_SLT, 5'd20, 5'd2, 5'd1);
        run_op("sltu pos neg", 7'd0, FUNCT3_SLTU, 5'd21, 5'd2, 5'd1);
        run_op_imm("slti", FUNCT3_SLT, rand_bits(12), 5'd3, 5'd22);
        run_op_imm("sltiu", FUNCT3_SLTU, rand_bits(12), 5'd7, 5'd22);
    endtask

    task automatic test_branch();
        funct3_t  conds [6];
        reg_idx_t ra [3];
        reg_idx_t rb [3];
        word_t    imm;
        conds = '{FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT, FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU};
        ra    = '{5'd1, 5'd1, 5'd2};                 // Equal, x1 negative vs x2 positive
        rb    = '{5'd1, 5'd2, 5'd1};
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                imm = rand_bits(12) << 1;
                run($sformatf("branch f3=%0d pair %0d", conds[c], p),
                    enc_b(imm, rb[p], ra[p], conds[c]), pc_now + sext13(imm),
                    branch_ref(conds[c], mirror[ra[p]], mirror[rb[p]]), 1'b0);
            end
        end
        for (int i = 1; i <= 22; i++) readback(reg_idx_t'(i));  // Branches write nothing
    endtask

    task automatic test_jump_upper();
        word_t imm;
        imm = rand_bits(20) << 1;
        run("jal", enc_j(imm, 5'd23), pc_now + 32'd4, 1'b1, 1'b1);
        idle_hold("jal idle", 2);                    // Taken flag stays up while idle
        imm = rand_bits(12);
        run("jalr", enc_i(OPCODE_JALR, imm, 5'd3, 3'b000, 5'd24), pc_now + 32'd4, 1'b1, 1'b1);
        imm = rand_bits(20) << 12;
        run("lui", enc_u(OPCODE_LUI, imm, 5'd25), imm, 1'b0, 1'b1);
        imm = rand_bits(20) << 12;
        run("auipc", enc_u(OPCODE_AUIPC, imm, 5'd26), pc_now + imm, 1'b0, 1'b1);
        for (int i = 23; i <= 26; i++) readback(reg_idx_t'(i));
    endtask

    task automatic test_mem_b2b();
        word_t imm;
        imm = rand_bits(12);
        run("lw", enc_i(OPCODE_LOAD, imm, 5'd3, 3'b010, 5'd27),
            mirror[3] + sext12(imm), 1'b0, 1'b0);
        imm = rand_bits(12);
        run("sw", enc_s(imm, 5'd4, 5'd5), mirror[5] + sext12(imm), 1'b0, 1'b0);
        readback(5'd27);                             // Load target still zero
        // Issued on consecutive edges, each reads the previous write
        run_op_imm("b2b addi", FUNCT3_ADD_SUB, rand_bits(12), 5'd1, 5'd28);
        run_op("b2b add", 7'd0, FUNCT3_ADD_SUB, 5'd29, 5'd28, 5'd2);
        run_op("b2b sub", FUNCT7_SUB, FUNCT3_ADD_SUB, 5'd30, 5'd29, 5'd28);
        idle_hold("b2b idle", 1);                    // One result per instruction
    endtask

    initial begin
        lfsr_state = 32'h45d;
        pc_now     = 32'h0000_1000;
        last_res   = '0;
        last_br    = 1'b0;
        last_rd    = '0;
        for (int i = 0; i < REG_COUNT; i++) mirror[i] = '0;
        arst_n = 1'b0;
        valid  = 1'b0;
        instr  = '0;
        pc     = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_arith();
        test_shift_compare();
        test_branch();
        test_jump_upper();
        test_mem_b2b();
        $display("NO ERRORS");
        $finish;
    end

endmodule : execute_tb

/* project.f */
source/riscv_pkg.sv
source/branch_control.sv
source/alu.sv
source/decoder.sv
source/regfile.sv
source/execute_stage.sv
test/execute_checker.sv
test/execute_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

obj_dir/Vexecute_tb: project.f $(shell cat project.f)
	verilator --binary --timing --assert --top-module execute_tb -f project.f

.PHONY: run clean

run: obj_dir/Vexecute_tb
	./obj_dir/Vexecute_tb

clean:
	rm -rf obj_dir
